// File: bench/lbp_checker.sv
`default_nettype none

module lbp_checker (
    input logic clk,
    input logic rst,
    input logic gray_oe,
    input logic lbp_wen,
    input logic finish,
    input logic theta_valid,
    input logic cos_valid
);
    timeunit 1ns;
    timeprecision 100ps;

    assert property (@(posedge clk) disable iff (rst) !(gray_oe && lbp_wen))
        else $error("gray read and lbp write in the same cycle");

    assert property (@(posedge clk) disable iff (rst) finish |=> !finish)
        else $error("finish held longer than one cycle");

    assert property (@(posedge clk) disable iff (rst) !(theta_valid && gray_oe))
        else $error("angle request during a gray read");

    // answer comes exactly one cycle after each request
    assert property (@(posedge clk) disable iff (rst) cos_valid == $past(theta_valid))
        else $error("cos_valid does not follow theta_valid by one cycle");

endmodule

bind lbp_top lbp_checker lbp_checker_i (
    .clk         (clk),
    .rst         (rst),
    .gray_oe     (gray_oe),
    .lbp_wen     (lbp_wen),
    .finish      (finish),
    .theta_valid (theta_valid),
    .cos_valid   (cos_valid)
);

`default_nettype wire

// File: bench/lbp_tb.sv
`default_nettype none

module lbp_tb import lbp_pkg::*; ();
    timeunit 1ns;
    timeprecision 100ps;

    localparam longint pi_scaled   = 205887;
    localparam longint watchdog_ns = (2 * 64 * 64 * 42 + 2000) * 10;

    logic      clk;
    logic      rst;
    logic      enable;
    fix_t      theta;
    logic      theta_valid;
    fix_t      cos_data;
    logic      cos_valid;
    fix_t      sin_data;
    logic      sin_valid;
    img_addr_t gray_addr;
    logic      gray_oe;
    gray_t     gray_data;
    img_addr_t lbp_addr;
    logic      lbp_wen;
    lbp_code_t lbp_data;
    logic      finish;

    // cos and sin of k*pi/4 with 16 fraction bits
    int cos_tab [8] = '{65536, 46341, 0, -46341, -65536, -46341, 0, 46341};
    int sin_tab [8] = '{0, 46341, 65536, 46341, 0, -46341, -65536, -46341};

    gray_t       gray_mem [4096];
    lbp_code_t   expected_code [4096];
    logic [15:0] lfsr_state;
    int          req_count;
    int          next_write;
    int          finish_count;
    logic        last_write_seen;
    logic        rd_pending;
    img_addr_t   rd_addr;
    logic        req_seen;
    longint      req_theta;
    int          req_k;

    lbp_top lbp_top_i (.*);

    always #5 clk = ~clk;

    ////////////////////////////////////////////////////////////
    // checks and random numbers
    ////////////////////////////////////////////////////////////

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("Checks failed");
        $fatal(1, "simulation stopped at the first failure");
    endtask

    task automatic check_value(input string name, input longint expected, input longint actual);
        if (expected != actual)
            fail_run($sformatf("Error in %s: expected %0d, actual %0d", name, expected, actual));
    endtask

    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};    // x^16+x^14+x^13+x^11+1
    endfunction

    function automatic logic [15:0] rand_bits(input int n);
        logic [15:0] v;
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr_state = lfsr_step(lfsr_state);
            v = {v[14:0], lfsr_state[0]};
        end
        return v;
    endfunction

    ////////////////////////////////////////////////////////////
    // reference model
    ////////////////////////////////////////////////////////////

    function automatic logic is_border(input int pix);
        int row;
        int col;
        row = pix / 64;
        col = pix % 64;
        return (row < 3) || (row > 60) || (col < 3) || (col > 60);
    endfunction

    function automatic longint gray_at(input int pix, input int dx, input int dy);
        return longint'(gray_mem[pix + dx + 64 * dy]);
    endfunction

    function automatic lbp_code_t model_code(input int pix);
        lbp_code_t code;
        longint    rx;
        longint    ry;
        longint    tx;
        longint    ty;
        longint    ux;
        longint    uy;
        longint    sum;
        longint    rounded;
        int        x1;
        int        x2;
        int        y1;
        int        y2;
        code = '0;
        if (!is_border(pix))
        begin
            for (int k = 0; k < 8; k++)
            begin
                rx = 3 * longint'(cos_tab[k]);
                ry = -3 * longint'(sin_tab[k]);    // rows grow downward
                x1 = int'(rx >>> 16);
                y1 = int'(ry >>> 16);
                tx = rx - 65536 * longint'(x1);
                ty = ry - 65536 * longint'(y1);
                x2 = (tx != 0) ? x1 + 1 : x1;
                y2 = (ty != 0) ? y1 + 1 : y1;
                ux = 65536 - tx;
                uy = 65536 - ty;
                sum = ((ux * uy) >>> 16) * gray_at(pix, x1, y1)
                    + ((tx * uy) >>> 16) * gray_at(pix, x2, y1)
                    + ((ux * ty) >>> 16) * gray_at(pix, x1, y2)
                    + ((tx * ty) >>> 16) * gray_at(pix, x2, y2);
                rounded = ((sum >>> 16) + ((sum >>> 15) & 1)) & 511;
                if (rounded >= longint'(gray_mem[pix]))
                    code[k] = 1'b1;
            end
        end
        return code;
    endfunction

    function automatic int find_angle(input longint value);
        int k;
        k = -1;
        for (int i = 0; i < 8; i++)
            if (((2 * pi_scaled * i) >>> 3) == value)
                k = i;
        return k;
    endfunction

    ////////////////////////////////////////////////////////////
    // external units
    ////////////////////////////////////////////////////////////

    always @(posedge clk)
    begin
        rd_pending = gray_oe;
        rd_addr    = gray_addr;
        #1;
        if (rd_pending)
            gray_data = gray_mem[rd_addr];    // valid for the next edge
    end

    always @(posedge clk)
    begin
        req_seen  = theta_valid;
        req_theta = longint'(theta.raw);
        #1;
        cos_valid = 1'b0;
        sin_valid = 1'b0;
        if (req_seen)
        begin
            req_k = find_angle(req_theta);
            if (req_k < 0)
                fail_run($sformatf("angle request with unknown theta %0d", req_theta));
            else
            begin
                check_value("theta request order", req_count, req_k);
                cos_data.raw = 25'(cos_tab[req_k]);
                sin_data.raw = 25'(sin_tab[req_k]);
                cos_valid    = 1'b1;
                sin_valid    = 1'b1;
                req_count++;
            end
        end
    end

    // write and finish monitor
    always @(posedge clk)
    begin
        if (!rst)
        begin
            if (finish)
            begin
                check_value("finish after write to 4095", 1, longint'(last_write_seen));
                check_value("writes before finish", 4096, next_write);
                finish_count++;
            end
            last_write_seen = 1'b0;
            if (lbp_wen)
            begin
                check_value("write address", next_write, longint'(lbp_addr));
                if (is_border(int'(lbp_addr)))
                    check_value("border code", 0, longint'(lbp_data));
                else
                    check_value("interior code", longint'(expected_code[lbp_addr]),
                                longint'(lbp_data));
                last_write_seen = (lbp_addr == 12'd4095);
                next_write++;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // test flow
    ////////////////////////////////////////////////////////////

    task automatic run_frame(input int frame_no);
        logic [15:0] gap;
        for (int i = 0; i < 4096; i++)
            gray_mem[i] = gray_t'(rand_bits(8));
        for (int i = 0; i < 4096; i++)
            expected_code[i] = model_code(i);
        next_write = 0;
        gap = rand_bits(4);
        repeat (int'(gap) + 2) @(posedge clk);
        #1;
        enable = 1'b1;
        @(posedge clk);
        #1;
        enable = 1'b0;
        wait (finish_count == frame_no);
        repeat (4) @(posedge clk);
        #1;
        check_value("finish pulses", frame_no, finish_count);
        check_value("writes per frame", 4096, next_write);
        check_value("theta requests", 8, req_count);    // table is kept for frame 2
    endtask

    initial
    begin
        #(watchdog_ns);
        fail_run("timeout: the DUT did not finish both frames in time");
    end

    initial
    begin
        clk          = 1'b0;
        rst          = 1'b1;
        enable       = 1'b0;
        cos_data     = '0;
        sin_data     = '0;
        cos_valid    = 1'b0;
        sin_valid    = 1'b0;
        gray_data    = '0;
        lfsr_state   = 16'd19840;
        req_count    = 0;
        next_write   = 0;
        finish_count = 0;
        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;
        run_frame(1);
        run_frame(2);
        $display("All checks passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: compile.f
hw/lbp_pkg.sv
hw/angle_table.sv
hw/sample_geometry.sv
hw/pixel_sequencer.sv
hw/bilinear_cmp.sv
hw/lbp_top.sv
bench/lbp_checker.sv
bench/lbp_tb.sv

// File: hw/angle_table.sv
`default_nettype none

module angle_table import lbp_pkg::*; #(
    parameter int int_width  = lbp_pkg::int_width,
    parameter int frac_width = lbp_pkg::frac_width
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        start,
    input  fix_t        cos_data,
    input  fix_t        sin_data,
    input  logic        cos_valid,
    input  logic        sin_valid,
    input  sample_idx_t sel,
    output fix_t        theta,
    output logic        theta_valid,
    output logic        table_ready,
    output trig_t       trig
);

    localparam int fix_w = int_width + frac_width;

    sample_idx_t      req_idx;
    sample_idx_t      rsp_idx;
    logic             rsp_pending;
    logic [fix_w+3:0] angle_prod;
    trig_t            table_mem [n_samples];

    assign angle_prod = {pi_fix.raw, 1'b0} * req_idx;    // 2*pi*k, shifted down by 3 below

    always_comb
    begin
        theta = '0;
        if (theta_valid)
            theta.raw = angle_prod[fix_w+2:3];
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            req_idx     <= '0;
            theta_valid <= 1'b0;
            rsp_idx     <= '0;
            rsp_pending <= 1'b0;
            table_ready <= 1'b0;
        end
        else
        begin
            rsp_pending <= theta_valid;    // answer comes one cycle after the request
            rsp_idx     <= req_idx;
            if (start)
            begin
                theta_valid <= 1'b1;
                req_idx     <= '0;
                table_ready <= 1'b0;
            end
            else if (theta_valid)
            begin
                req_idx <= req_idx + 1'b1;
                if (req_idx == sample_idx_t'(n_samples - 1))
                    theta_valid <= 1'b0;
            end
            if (rsp_pending && rsp_idx == sample_idx_t'(n_samples - 1))
                table_ready <= 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (rsp_pending && cos_valid)
            table_mem[rsp_idx].cos <= cos_data;
        if (rsp_pending && sin_valid)
            table_mem[rsp_idx].sin <= sin_data;
    end

    assign trig = table_mem[sel];

endmodule

`default_nettype wire

// File: hw/bilinear_cmp.sv
`default_nettype none

module bilinear_cmp import lbp_pkg::*; #(
    parameter int int_width  = lbp_pkg::int_width,
    parameter int frac_width = lbp_pkg::frac_width
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        acc_clear,
    input  logic        corner_valid,
    input  logic [1:0]  corner_sel,
    input  gray_t       gray_data,
    input  sample_geo_t geo,
    input  gray_t       center,
    output logic        bit_out
);

    localparam int acc_w = int_width + frac_width + 1;

    logic [frac_width:0]  weight;
    logic [acc_w-1:0]     acc;
    logic [int_width-1:0] rounded;

    always_comb
    begin
        case (corner_sel)
            2'd0:    weight = geo.w11;
            2'd1:    weight = geo.w21;
            2'd2:    weight = geo.w12;
            default: weight = geo.w22;
        endcase
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            acc <= '0;
        else if (acc_clear)
            acc <= '0;
        else if (corner_valid)
            acc <= acc + gray_data * weight;
    end

    // round half up on the top fraction bit
    assign rounded = acc[frac_width +: int_width] + int_width'(acc[frac_width-1]);
    assign bit_out = (rounded >= int_width'(center));

endmodule

`default_nettype wire

// File: hw/lbp_pkg.sv
`default_nettype none

package lbp_pkg;

    ////////////////////////////////////////////////////////////
    // fixed point format
    ////////////////////////////////////////////////////////////

    localparam int int_width  = 9;
    localparam int frac_width = 16;

    // raw view for arithmetic, parts view for floor and fraction tests
    typedef union packed {
        logic signed [int_width+frac_width-1:0] raw;
        struct packed {
            logic signed [int_width-1:0] ipart;
            logic [frac_width-1:0]       frac;
        } parts;
    } fix_t;

    localparam fix_t fix_one = 25'sd65536;
    localparam fix_t pi_fix  = 25'sd205887;

    ////////////////////////////////////////////////////////////
    // image and pattern
    ////////////////////////////////////////////////////////////

    localparam int img_side   = 64;
    localparam int lbp_radius = 3;
    localparam int n_samples  = 8;

    typedef logic [11:0] img_addr_t;
    typedef logic [2:0]  sample_idx_t;
    typedef logic [7:0]  gray_t;
    typedef logic [7:0]  lbp_code_t;

    typedef struct packed {
        fix_t cos;
        fix_t sin;
    } trig_t;

    // corner offsets and the weight of each corner
    typedef struct packed {
        logic signed [8:0] dx1;
        logic signed [8:0] dx2;
        logic signed [8:0] dy1;
        logic signed [8:0] dy2;
        logic [16:0]       w11;    // (x1,y1)
        logic [16:0]       w21;    // (x2,y1)
        logic [16:0]       w12;    // (x1,y2)
        logic [16:0]       w22;    // (x2,y2)
    } sample_geo_t;

endpackage

`default_nettype wire

// File: hw/lbp_top.sv
`default_nettype none

module lbp_top import lbp_pkg::*; #(
    parameter int int_width  = lbp_pkg::int_width,
    parameter int frac_width = lbp_pkg::frac_width
) (
    input  logic      clk,
    input  logic      rst,
    input  logic      enable,
    output fix_t      theta,
    output logic      theta_valid,
    input  fix_t      cos_data,
    input  logic      cos_valid,
    input  fix_t      sin_data,
    input  logic      sin_valid,
    output img_addr_t gray_addr,
    output logic      gray_oe,
    input  gray_t     gray_data,
    output img_addr_t lbp_addr,
    output logic      lbp_wen,
    output lbp_code_t lbp_data,
    output logic      finish
);

    logic        start;
    logic        table_ready;
    sample_idx_t sel;
    trig_t       trig;
    sample_geo_t geo;
    logic        acc_clear;
    logic [1:0]  corner_sel;
    logic        corner_valid;
    gray_t       center;
    logic        bit_out;

    angle_table #(
        .int_width  (int_width),
        .frac_width (frac_width)
    ) angle_table_i (
        .clk         (clk),
        .rst         (rst),
        .start       (start),
        .cos_data    (cos_data),
        .sin_data    (sin_data),
        .cos_valid   (cos_valid),
        .sin_valid   (sin_valid),
        .sel         (sel),
        .theta       (theta),
        .theta_valid (theta_valid),
        .table_ready (table_ready),
        .trig        (trig)
    );

    sample_geometry #(
        .int_width  (int_width),
        .frac_width (frac_width)
    ) sample_geometry_i (
        .trig (trig),
        .geo  (geo)
    );

    pixel_sequencer pixel_sequencer_i (
        .clk          (clk),
        .rst          (rst),
        .enable       (enable),
        .table_ready  (table_ready),
        .geo          (geo),
        .gray_data    (gray_data),
        .bit_in       (bit_out),
        .start        (start),
        .sel          (sel),
        .gray_addr    (gray_addr),
        .gray_oe      (gray_oe),
        .acc_clear    (acc_clear),
        .corner_sel   (corner_sel),
        .corner_valid (corner_valid),
        .center       (center),
        .lbp_addr     (lbp_addr),
        .lbp_wen      (lbp_wen),
        .lbp_data     (lbp_data),
        .finish       (finish)
    );

    bilinear_cmp #(
        .int_width  (int_width),
        .frac_width (frac_width)
    ) bilinear_cmp_i (
        .clk          (clk),
        .rst          (rst),
        .acc_clear    (acc_clear),
        .corner_valid (corner_valid),
        .corner_sel   (corner_sel),
        .gray_data    (gray_data),
        .geo          (geo),
        .center       (center),
        .bit_out      (bit_out)
    );

endmodule

`default_nettype wire

// File: hw/pixel_sequencer.sv
`default_nettype none

module pixel_sequencer import lbp_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        enable,
    input  logic        table_ready,
    input  sample_geo_t geo,
    input  gray_t       gray_data,
    input  logic        bit_in,
    output logic        start,
    output sample_idx_t sel,
    output img_addr_t   gray_addr,
    output logic        gray_oe,
    output logic        acc_clear,
    output logic [1:0]  corner_sel,
    output logic        corner_valid,
    output gray_t       center,
    output img_addr_t   lbp_addr,
    output logic        lbp_wen,
    output lbp_code_t   lbp_data,
    output logic        finish
);

    localparam int        side_bits = $clog2(img_side);
    localparam img_addr_t last_pix  = img_addr_t'(img_side * img_side - 1);

    typedef enum logic [2:0] {s_idle, s_load, s_pixel, s_sample, s_write} state_t;

    state_t               state;
    img_addr_t            pix;
    sample_idx_t          k;
    logic [2:0]           phase;    // 0..3 corner reads, 4 compare
    logic                 center_pend;
    logic [n_samples-2:0] code_lo;
    logic [side_bits-1:0] row;
    logic [side_bits-1:0] col;
    logic                 border;
    logic signed [8:0]    dx;
    logic signed [8:0]    dy;
    img_addr_t            corner_addr;

    ////////////////////////////////////////////////////////////
    // border test and corner address
    ////////////////////////////////////////////////////////////

    assign row = pix[2*side_bits-1:side_bits];
    assign col = pix[side_bits-1:0];
    assign border = (row < lbp_radius) || (row >= img_side - lbp_radius) ||
                    (col < lbp_radius) || (col >= img_side - lbp_radius);

    // corner order x1y1, x2y1, x1y2, x2y2
    assign dx = phase[0] ? geo.dx2 : geo.dx1;
    assign dy = phase[1] ? geo.dy2 : geo.dy1;
    assign corner_addr = pix + {{3{dx[8]}}, dx} + ({{3{dy[8]}}, dy} << side_bits);

    assign sel      = k;
    assign lbp_addr = pix;

    always_comb
    begin
        start     = 1'b0;
        gray_oe   = 1'b0;
        gray_addr = pix;
        acc_clear = 1'b0;
        lbp_wen   = 1'b0;
        lbp_data  = '0;
        case (state)
            s_idle:
                start = enable && !table_ready;
            s_pixel:
            begin
                lbp_wen = border;    // border code stays 0
                gray_oe = !border;   // center read
            end
            s_sample:
            begin
                gray_oe   = (phase < 3'd4);
                gray_addr = corner_addr;
                acc_clear = (phase == 3'd0);
            end
            s_write:
            begin
                lbp_wen  = 1'b1;
                lbp_data = {bit_in, code_lo};
            end
            default:
                ;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // control
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            state        <= s_idle;
            pix          <= '0;
            k            <= '0;
            phase        <= '0;
            center_pend  <= 1'b0;
            corner_valid <= 1'b0;
            corner_sel   <= '0;
            finish       <= 1'b0;
        end
        else
        begin
            center_pend  <= (state == s_pixel) && !border;
            corner_valid <= (state == s_sample) && (phase < 3'd4);    // lines up with gray_data
            corner_sel   <= phase[1:0];
            finish       <= lbp_wen && (pix == last_pix);
            case (state)
                s_idle:
                begin
                    pix <= '0;
                    if (enable)
                        state <= table_ready ? s_pixel : s_load;
                end
                s_load:
                    if (table_ready)
                        state <= s_pixel;
                s_pixel:
                begin
                    k     <= '0;
                    phase <= '0;
                    if (!border)
                        state <= s_sample;
                    else if (pix == last_pix)
                        state <= s_idle;
                    else
                        pix <= pix + 1'b1;
                end
                s_sample:
                begin
                    if (phase == 3'd4)
                    begin
                        phase <= '0;
                        k     <= k + 1'b1;
                        if (k == sample_idx_t'(n_samples - 1))
                            state <= s_write;
                    end
                    else
                        phase <= phase + 1'b1;
                end
                s_write:
                begin
                    if (pix == last_pix)
                        state <= s_idle;
                    else
                    begin
                        pix   <= pix + 1'b1;
                        state <= s_pixel;
                    end
                end
                default:
                    state <= s_idle;
            endcase
        end
    end

    // bit of the previous sample is ready while the next one starts
    always_ff @(posedge clk)
    begin
        if (center_pend)
            center <= gray_data;
        if (state == s_sample && phase == 3'd0 && k != '0)
            code_lo[k - 1'b1] <= bit_in;
    end

endmodule

`default_nettype wire

// File: hw/sample_geometry.sv
`default_nettype none

module sample_geometry import lbp_pkg::*; #(
    parameter int int_width  = lbp_pkg::int_width,
    parameter int frac_width = lbp_pkg::frac_width
) (
    input  trig_t       trig,
    output sample_geo_t geo
);

    localparam logic [frac_width:0] w_one = fix_one.raw[frac_width:0];

    fix_t                        rx;
    fix_t                        ry;
    logic signed [int_width-1:0] x1;
    logic signed [int_width-1:0] y1;
    logic [frac_width:0]         tx;
    logic [frac_width:0]         ty;
    logic [frac_width:0]         ux;
    logic [frac_width:0]         uy;
    logic [2*frac_width+1:0]     p11;
    logic [2*frac_width+1:0]     p21;
    logic [2*frac_width+1:0]     p12;
    logic [2*frac_width+1:0]     p22;

    always_comb
    begin
        rx.raw = trig.cos.raw * 25'(lbp_radius);
        ry.raw = -(trig.sin.raw * 25'(lbp_radius));    // image rows grow downward

        x1 = rx.parts.ipart;    // floor
        y1 = ry.parts.ipart;
        tx = {1'b0, rx.parts.frac};
        ty = {1'b0, ry.parts.frac};
        ux = w_one - tx;
        uy = w_one - ty;

        p11 = ux * uy;
        p21 = tx * uy;
        p12 = ux * ty;
        p22 = tx * ty;

        geo.dx1 = x1;
        geo.dx2 = (rx.parts.frac != '0) ? x1 + 1'b1 : x1;
        geo.dy1 = y1;
        geo.dy2 = (ry.parts.frac != '0) ? y1 + 1'b1 : y1;

        // keep 16 fraction bits, 1.0 still fits in 17
        geo.w11 = p11[frac_width +: frac_width+1];
        geo.w21 = p21[frac_width +: frac_width+1];
        geo.w12 = p12[frac_width +: frac_width+1];
        geo.w22 = p22[frac_width +: frac_width+1];
    end

endmodule

`default_nettype wire

// File: run_sim.sh
#!/usr/bin/env bash
# builds the LBP bench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module lbp_tb -f compile.f -o lbp_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/lbp_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "^All checks passed$"; then
    exit 0
fi
echo "pass message not found in simulation output"
exit 1
